// ==== logic/core_consts.svh ====
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

`define DATA_WIDTH 16
`define REG_COUNT  4

// register codes
`define RA 2'd0
`define RB 2'd1
`define RC 2'd2
`define RD 2'd3

// groups 2 and 3 are not decoded
`define GROUP_ALU 2'd0
`define GROUP_LDS 2'd1

// --------------------
// alu group
`define ALU_OP_MOV 3'd0
`define ALU_OP_ADD 3'd1
`define ALU_OP_SUB 3'd2
`define ALU_OP_AND 3'd3
`define ALU_OP_OR  3'd4
`define ALU_OP_XOR 3'd5

`define MODE_REGA_U8   3'd0
`define MODE_REGB_U8   3'd1
`define MODE_REGA_U8RB 3'd2 // imm8 is the high byte
`define MODE_REGB_U8RA 3'd3
`define MODE_REGA_REGB 3'd4

// --------------------
// load/store group
`define LDS_INC_NONE 2'd0
`define LDS_POST_INC 2'd1
`define LDS_PRE_DEC  2'd2

`define LDS_OP_LD  2'd0
`define LDS_OP_ST  2'd1
`define LDS_OP_STB 2'd2

`endif

// ==== logic/isaPkg.sv ====
package isaPkg;

	// --------------------
	// alu format
	typedef struct packed {
		logic [1:0] group;
		logic [2:0] op;
		logic [2:0] mode;
		logic [7:0] imm8;
	} aluFmt;

	// --------------------
	// load/store format
	typedef struct packed {
		logic [1:0] group;
		logic [1:0] incf;     // pointer update
		logic [1:0] opf;      // access kind
		logic [5:0] reserved;
		logic [1:0] dataReg;
		logic [1:0] ptrReg;
	} ldsFmt;

	// one fetched word, both views at once
	typedef union packed {
		aluFmt alu;
		ldsFmt lds;
	} instrWord;

endpackage

// ==== logic/busPkg.sv ====
`include "core_consts.svh"

package busPkg;

	typedef enum logic [1:0] {
		phFetch   = 2'd0,
		phDecode  = 2'd1,
		phExecute = 2'd2,
		phCommit  = 2'd3
	} corePhase;

	// strobes are low active
	typedef struct packed {
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] data;
		logic rdn;
		logic wrn0;
		logic wrn1;
	} busReq;

	typedef struct packed {
		logic valid;
		logic [1:0] destReg;
		logic [`DATA_WIDTH-1:0] value;
	} aluResult;

	typedef struct packed {
		logic isLoad;
		logic [1:0] dataReg;
		logic ptrWrite;
		logic [1:0] ptrReg;
		logic [`DATA_WIDTH-1:0] ptrNext;
	} ldsResult;

endpackage

// ==== logic/phaseSequencer.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module phaseSequencer (
	input  logic clk,
	input  logic rstN,
	input  logic [`DATA_WIDTH-1:0] din,
	output busPkg::corePhase phase,
	output isaPkg::instrWord instr,
	output logic [`DATA_WIDTH-1:0] pc,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	logic [1:0] phaseCount;
	logic [3:0] phaseLevels;

	assign phase = busPkg::corePhase'(phaseCount);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			phaseCount <= 2'd0;
			pc <= '0;
			instr <= '0;
		end else begin
			phaseCount <= phaseCount + 2'd1; // wraps commit -> fetch
			if (phase == busPkg::phFetch) begin
				instr <= din;
				pc <= pc + `DATA_WIDTH'(2);
			end
		end
	end

	assign fetch   = (phase == busPkg::phFetch);
	assign decode  = (phase == busPkg::phDecode);
	assign execute = (phase == busPkg::phExecute);
	assign commit  = (phase == busPkg::phCommit);

	assign phaseLevels = {commit, execute, decode, fetch};

	// one level high, moving one step per clock
	phaseRotate: assert property (@(posedge clk) disable iff (!rstN)
		$past(rstN) |-> $onehot(phaseLevels)
			&& phaseLevels == {$past(phaseLevels[2:0]), $past(phaseLevels[3])})
		else $error("phase levels out of sequence: %b", phaseLevels);

endmodule

// ==== logic/aluUnit.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module aluUnit (
	input  busPkg::corePhase phase,
	input  isaPkg::instrWord instr,
	input  logic [`DATA_WIDTH-1:0] regA,
	input  logic [`DATA_WIDTH-1:0] regB,
	output busPkg::aluResult result
);

	isaPkg::aluFmt fmt;
	logic isAlu;
	logic modeKnown;
	logic inExecute;
	logic [1:0] destReg;
	logic [`DATA_WIDTH-1:0] operand;
	logic [`DATA_WIDTH-1:0] oldValue;
	logic [`DATA_WIDTH-1:0] value;

	assign fmt = instr.alu;
	assign isAlu = (fmt.group == `GROUP_ALU);
	assign inExecute = (phase == busPkg::phExecute);

	// --------------------
	// destination and second operand
	always_comb begin
		modeKnown = 1'b1;
		destReg = `RA;
		oldValue = regA;
		operand = {{(`DATA_WIDTH-8){1'b0}}, fmt.imm8};
		case (fmt.mode)
			`MODE_REGA_U8: begin
				destReg = `RA;
			end
			`MODE_REGB_U8: begin
				destReg = `RB;
				oldValue = regB;
			end
			`MODE_REGA_U8RB: operand = {fmt.imm8, regB[7:0]};
			`MODE_REGB_U8RA: begin
				destReg = `RB;
				oldValue = regB;
				operand = {fmt.imm8, regA[7:0]};
			end
			`MODE_REGA_REGB: operand = regB;
			default: modeKnown = 1'b0;
		endcase
	end

	// --------------------
	// operations
	always_comb begin
		case (fmt.op)
			`ALU_OP_MOV: value = operand;
			`ALU_OP_ADD: value = oldValue + operand;
			`ALU_OP_SUB: value = oldValue - operand;
			`ALU_OP_AND: value = oldValue & operand;
			`ALU_OP_OR:  value = oldValue | operand;
			`ALU_OP_XOR: value = oldValue ^ operand;
			default:     value = oldValue; // spare opcodes keep the register
		endcase
	end

	assign result.valid = isAlu && modeKnown;
	assign result.destReg = destReg;
	assign result.value = value;

	// checked as execute ends, instr is stable by then
	aluModeKnown: assert property (@(negedge inExecute) isAlu |-> modeKnown)
		else $error("unknown alu mode %0d", fmt.mode);

endmodule

// ==== logic/loadStoreUnit.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module loadStoreUnit (
	input  busPkg::corePhase phase,
	input  isaPkg::instrWord instr,
	input  logic [`DATA_WIDTH-1:0] pc,
	input  logic [`DATA_WIDTH-1:0] ptrVal,
	input  logic [`DATA_WIDTH-1:0] dataVal,
	output busPkg::ldsResult result,
	output busPkg::busReq bus
);

	isaPkg::ldsFmt fmt;
	logic isLds;
	logic isLoad;
	logic isByte;
	logic isStore;
	logic isAccess;
	logic inCommit;
	logic [`DATA_WIDTH-1:0] step;
	logic [`DATA_WIDTH-1:0] effAddr;
	logic [`DATA_WIDTH-1:0] ptrNext;
	logic [`DATA_WIDTH-1:0] storeData;

	assign fmt = instr.lds;
	assign isLds = (fmt.group == `GROUP_LDS);
	assign isLoad = isLds && (fmt.opf == `LDS_OP_LD);
	assign isByte = isLds && (fmt.opf == `LDS_OP_STB);
	assign isStore = isByte || (isLds && fmt.opf == `LDS_OP_ST);
	assign isAccess = isLoad || isStore;
	assign inCommit = (phase == busPkg::phCommit);

	// --------------------
	// address and pointer
	assign step = isByte ? `DATA_WIDTH'(1) : `DATA_WIDTH'(2);
	assign effAddr = (fmt.incf == `LDS_PRE_DEC) ? ptrVal - step : ptrVal;

	always_comb begin
		case (fmt.incf)
			`LDS_POST_INC: ptrNext = ptrVal + step;
			`LDS_PRE_DEC:  ptrNext = effAddr;
			default:       ptrNext = ptrVal;
		endcase
	end

	assign storeData = isByte ? {dataVal[7:0], dataVal[7:0]} : dataVal; // byte on both lanes

	assign result.isLoad = isLoad;
	assign result.dataReg = fmt.dataReg;
	assign result.ptrWrite = isAccess
		&& (fmt.incf == `LDS_POST_INC || fmt.incf == `LDS_PRE_DEC);
	assign result.ptrReg = fmt.ptrReg;
	assign result.ptrNext = ptrNext;

	// --------------------
	// bus drive per phase
	always_comb begin
		bus.addr = pc;
		bus.data = storeData;
		bus.rdn = 1'b1;
		bus.wrn0 = 1'b1;
		bus.wrn1 = 1'b1;
		case (phase)
			busPkg::phFetch: bus.rdn = 1'b0;
			busPkg::phExecute: begin
				if (isAccess) bus.addr = effAddr;
			end
			busPkg::phCommit: begin
				if (isAccess) bus.addr = effAddr;
				if (isLoad) bus.rdn = 1'b0;
				if (isStore) begin
					bus.wrn0 = isByte && effAddr[0];  // even lane
					bus.wrn1 = isByte && !effAddr[0]; // odd lane
				end
			end
			default: ;
		endcase
	end

	noReadWhileWrite: assert property (@(negedge inCommit) bus.rdn || (bus.wrn0 && bus.wrn1))
		else $error("read and write strobes low together at %h", bus.addr);

endmodule

// ==== logic/regCommit.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module regCommit (
	input  logic clk,
	input  logic rstN,
	input  busPkg::corePhase phase,
	input  isaPkg::instrWord instr,
	input  logic [`DATA_WIDTH-1:0] din,
	input  busPkg::aluResult aluRes,
	input  busPkg::ldsResult ldsRes,
	output logic [`DATA_WIDTH-1:0] regA,
	output logic [`DATA_WIDTH-1:0] regB,
	output logic [`DATA_WIDTH-1:0] ptrVal,
	output logic [`DATA_WIDTH-1:0] dataVal
);

	logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] regFile;
	logic [`REG_COUNT-1:0][`DATA_WIDTH-1:0] nextFile;
	logic commitEnd;

	assign commitEnd = (phase == busPkg::phCommit);

	// --------------------
	// reads
	assign regA = regFile[`RA];
	assign regB = regFile[`RB];
	assign ptrVal = regFile[instr.lds.ptrReg];
	assign dataVal = regFile[instr.lds.dataReg];

	// --------------------
	// combined writeback, later writes take priority
	always_comb begin
		nextFile = regFile;
		if (aluRes.valid) begin
			nextFile[aluRes.destReg] = aluRes.value;
		end
		if (ldsRes.ptrWrite) begin
			nextFile[ldsRes.ptrReg] = ldsRes.ptrNext;
		end
		if (ldsRes.isLoad) begin
			nextFile[ldsRes.dataReg] = din; // load beats pointer update
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			regFile <= '0;
		end else if (commitEnd) begin
			regFile <= nextFile; // din sampled here for loads
		end
	end

endmodule

// ==== logic/core.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module core (
	input  logic clk,
	input  logic rstN,
	input  logic [`DATA_WIDTH-1:0] din,
	output logic [`DATA_WIDTH-1:0] addrBuf,
	output logic [`DATA_WIDTH-1:0] doutBuf,
	output logic rdnBuf,
	output logic wrn0Buf,
	output logic wrn1Buf,
	output logic fetch,
	output logic decode,
	output logic execute,
	output logic commit
);

	busPkg::corePhase phase;
	isaPkg::instrWord instr;
	busPkg::aluResult aluRes;
	busPkg::ldsResult ldsRes;
	busPkg::busReq busOut;
	logic [`DATA_WIDTH-1:0] pc;
	logic [`DATA_WIDTH-1:0] regA;
	logic [`DATA_WIDTH-1:0] regB;
	logic [`DATA_WIDTH-1:0] ptrVal;
	logic [`DATA_WIDTH-1:0] dataVal;

	phaseSequencer u_seq (
		.clk(clk),
		.rstN(rstN),
		.din(din),
		.phase(phase),
		.instr(instr),
		.pc(pc),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	// execute units, side by side
	aluUnit u_alu (
		.phase(phase),
		.instr(instr),
		.regA(regA),
		.regB(regB),
		.result(aluRes)
	);

	loadStoreUnit u_lds (
		.phase(phase),
		.instr(instr),
		.pc(pc),
		.ptrVal(ptrVal),
		.dataVal(dataVal),
		.result(ldsRes),
		.bus(busOut)
	);

	regCommit u_regs (
		.clk(clk),
		.rstN(rstN),
		.phase(phase),
		.instr(instr),
		.din(din),
		.aluRes(aluRes),
		.ldsRes(ldsRes),
		.regA(regA),
		.regB(regB),
		.ptrVal(ptrVal),
		.dataVal(dataVal)
	);

	// external bus pins
	assign addrBuf = busOut.addr;
	assign doutBuf = busOut.data;
	assign rdnBuf = busOut.rdn;
	assign wrn0Buf = busOut.wrn0;
	assign wrn1Buf = busOut.wrn1;

endmodule

// ==== testbench/coreTests.sv ====
`timescale 1ns/1ns
`include "core_consts.svh"

module coreTests;

	localparam int stimRecords = 26;
	localparam int phaseTimeout = 8; // cycles

	typedef struct packed {
		logic [`DATA_WIDTH-1:0] instr;
		logic [`DATA_WIDTH-1:0] loadData;
		logic [`DATA_WIDTH-1:0] addr;
		logic [`DATA_WIDTH-1:0] storeData;
		logic [2:0] strobes; // rdn, wrn0, wrn1
	} stimRec;

	logic clk;
	logic rstN;
	logic [`DATA_WIDTH-1:0] din;
	logic [`DATA_WIDTH-1:0] addrBuf;
	logic [`DATA_WIDTH-1:0] doutBuf;
	logic rdnBuf;
	logic wrn0Buf;
	logic wrn1Buf;
	logic fetch;
	logic decode;
	logic execute;
	logic commit;

	logic [`DATA_WIDTH-1:0] stimMem [0:stimRecords*5-1]; // five words per record
	stimRec recs [0:stimRecords-1];
	int mismatches;
	int failedTests;
	int testsRun;
	bit timedOut;

	core u_dut (
		.clk(clk),
		.rstN(rstN),
		.din(din),
		.addrBuf(addrBuf),
		.doutBuf(doutBuf),
		.rdnBuf(rdnBuf),
		.wrn0Buf(wrn0Buf),
		.wrn1Buf(wrn1Buf),
		.fetch(fetch),
		.decode(decode),
		.execute(execute),
		.commit(commit)
	);

	always #5 clk = ~clk;

	// --------------------
	// helpers
	task automatic checkValue(input logic [`DATA_WIDTH-1:0] actual,
		input logic [`DATA_WIDTH-1:0] expected, input string what);
		if (actual !== expected) begin
			mismatches++;
			$display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, actual, expected);
		end
	endtask

	function automatic logic levelOf(input logic [1:0] which);
		logic [3:0] levels;
		levels = {commit, execute, decode, fetch};
		return levels[which];
	endfunction

	function automatic logic [`DATA_WIDTH-1:0] strobeWord();
		return {13'd0, rdnBuf, wrn0Buf, wrn1Buf};
	endfunction

	// steps falling edges until the phase level is high
	task automatic waitPhase(input logic [1:0] which, input string name, output bit reached);
		int cycles;
		cycles = 0;
		while (!levelOf(which) && cycles < phaseTimeout) begin
			@(negedge clk);
			cycles++;
		end
		reached = levelOf(which);
		if (!reached) $display("timeout: %s phase not reached within %0d cycles", name, cycles);
	endtask

	// --------------------
	// main sequence
	initial begin
		bit reached;
		stimRec rec;
		int errorsBefore;
		clk = 1'b0;
		rstN = 1'b0;
		din = '0;
		mismatches = 0;
		failedTests = 0;
		testsRun = 0;
		timedOut = 1'b0;
		$readmemh("testbench/core_stim.txt", stimMem);
		for (int i = 0; i < stimRecords; i++) begin
			recs[i].instr = stimMem[5*i];
			recs[i].loadData = stimMem[5*i+1];
			recs[i].addr = stimMem[5*i+2];
			recs[i].storeData = stimMem[5*i+3];
			recs[i].strobes = stimMem[5*i+4][2:0];
		end

		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;

		for (int i = 0; i < stimRecords; i++) begin
			rec = recs[i];
			errorsBefore = mismatches;
			testsRun++;
			waitPhase(2'd0, "fetch", reached);
			if (!reached) begin
				timedOut = 1'b1;
				failedTests++;
				break;
			end
			checkValue(addrBuf, `DATA_WIDTH'(2 * i), "fetch address");
			checkValue(strobeWord(), 16'h0003, "strobes in fetch"); // only rdn low
			din = rec.instr;
			waitPhase(2'd1, "decode", reached);
			if (reached) begin
				checkValue(strobeWord(), 16'h0007, "strobes in decode");
				waitPhase(2'd2, "execute", reached);
			end
			if (reached) begin
				checkValue(strobeWord(), 16'h0007, "strobes in execute");
				if (rec.strobes != 3'b111) checkValue(addrBuf, rec.addr, "execute address");
				waitPhase(2'd3, "commit", reached);
			end
			if (!reached) begin
				timedOut = 1'b1;
				failedTests++;
				break;
			end
			if (rec.strobes != 3'b111) checkValue(addrBuf, rec.addr, "access address");
			if (!rec.strobes[1] || !rec.strobes[0]) begin
				checkValue(doutBuf, rec.storeData, "store data");
			end
			checkValue(strobeWord(), {13'd0, rec.strobes}, "strobes in commit");
			if (!rec.strobes[2]) din = rec.loadData; // taken as commit ends
			if (mismatches == errorsBefore) begin
				$display("test %0d (instr %h): ok", i, rec.instr);
			end else begin
				failedTests++;
				$display("test %0d (instr %h): %0d mismatches", i, rec.instr,
					mismatches - errorsBefore);
			end
		end

		$display("tests %0d, failed %0d, mismatches %0d", testsRun, failedTests, mismatches);
		if (mismatches == 0 && !timedOut) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== core.f ====
+incdir+logic
logic/isaPkg.sv
logic/busPkg.sv
logic/phaseSequencer.sv
logic/aluUnit.sv
logic/loadStoreUnit.sv
logic/regCommit.sv
logic/core.sv
testbench/coreTests.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module coreTests -f core.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output=$(./obj_dir/VcoreTests)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
exit 1

// ==== testbench/core_stim.txt ====
// columns: instruction, load data, expected address, expected store data, strobes
// strobes are {rdn, wrn0, wrn1} in commit; address and data unused where all strobes are high
01af 0000 0000 0000 7 // mov rb, af
02fa 0000 0000 0000 7 // mov ra, fa over rb low byte
0156 0000 0000 0000 7 // mov rb, 56
4404 0000 faaf 0056 4 // st (ra), rb
0c00 0000 0000 0000 7 // add ra, rb
5402 0000 0000 fb05 4 // st (rc)+, ra
1005 0000 0000 0000 7 // sub ra, 05
5402 0000 0002 fb00 4
1a3c 0000 0000 0000 7 // and ra, 3c over rb low byte
5402 0000 0004 3800 4
21a1 0000 0000 0000 7 // or rb, a1
5406 0000 0006 00f7 4 // st (rc)+, rb
2b12 0000 0000 0000 7 // xor rb, 12 over ra low byte
5406 0000 0008 12f7 4
500e 1234 000a 0000 3 // ld rd, (rc)+
5006 a5c3 000c 0000 3 // ld rb, (rc)+
540e 0000 000e 1234 4 // st (rc)+, rd
5406 0000 0010 a5c3 4
6002 7e81 0010 0000 3 // ld ra, -(rc)
4402 0000 0010 7e81 4 // st (rc), ra
5806 0000 0010 c3c3 5 // stb (rc)+, rb even
5806 0000 0011 c3c3 6 // odd
4402 0000 0012 7e81 4
6802 0000 0011 8181 6 // stb -(rc), ra
8000 0000 0000 0000 7 // group 2 no-op
4402 0000 0011 7e81 4
